/* surfturf_wrapper.f */
+incdir+hdl
hdl/rackbus_pkg.sv
hdl/turfio_pkg.sv
hdl/surfturf_register_core.sv
hdl/turfio_cmd_splice.sv
hdl/turf_command_link.sv
hdl/surf_command_port.sv
hdl/surfturf_wrapper.sv
testbench/surfturf_wrapper_tb.sv

/* Makefile */
SIM      = verilator
TOP      = surfturf_wrapper_tb
FILELIST = surfturf_wrapper.f
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only -Wall --timing
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# a crashed or aborted simulation is marked as failed in the log
run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/surfturf_wrapper_tb.sv */
`timescale 1ns/1ns
`include "surfturf_consts.svh"
`default_nettype none

module surfturf_wrapper_tb;
    import rackbus_pkg::*;
    import turfio_pkg::*;

    localparam int          TIMEOUT  = 200;
    localparam int          SURF_SEL = 3;
    localparam logic [31:0] TURF_CMD = 32'h1234_5678;
    localparam logic [31:0] RESP_VAL = 32'h5a0f_c3e1;

    logic                          clk;
    logic                          rst_n;
    wb_req_t                       wb_req;
    wb_rsp_t                       wb_rsp;
    logic                          sync;
    logic [31:0]                   turf_word;
    logic                          turf_strobe;
    logic [31:0]                   response;
    tfio_beat_t                    mode1;
    logic                          tfio_pps;
    logic                          use_tfio_pps;
    logic                          mode1_tready;
    surf_cmd_t                     command;
    logic                          command_valid;
    logic                          command_locked;
    logic [`SURFTURF_NUM_SURF-1:0] cin;
    int                            value_errors;
    int                            timeout_errors;
    int                            seed;
    logic [31:0]                   rdata;
    logic [31:0]                   word;

    surfturf_wrapper dut0 (
        .sysclk_i(clk), .rst_n_i(rst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
        .sync_i(sync), .turf_word_i(turf_word), .turf_word_strobe_i(turf_strobe),
        .response_i(response), .mode1_i(mode1), .tfio_pps_i(tfio_pps),
        .use_tfio_pps_i(use_tfio_pps), .mode1_tready_o(mode1_tready),
        .command_o(command), .command_valid_o(command_valid),
        .command_locked_o(command_locked), .cin_o(cin));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // sync pulse of one cycle every 40 cycles
    initial begin
        sync = 1'b0;
        repeat (6) @(posedge clk);
        forever begin
            repeat (39) @(posedge clk);
            #10 sync = 1'b1;
            @(posedge clk);
            #10 sync = 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_word);
        assert (got === exp_word) else begin
            value_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp_word);
        end
    endtask

    function automatic logic [11:0] slot_adr(input int slot, input int idx);
        return 12'((slot << `SURFTURF_SLOT_LSB) | (idx << 2));
    endfunction

    function automatic logic [11:0] core_adr(input int idx);
        return 12'((1 << `SURFTURF_CORE_BIT) | (idx << 2));
    endfunction

    // pps 31, runcmd 30:29, trig 28:14, fw 13:6, turf_low 5:0
    function automatic logic [31:0] splice_word(input logic [31:0] base, input logic [1:0] run,
                                                input logic [14:0] trig, input logic [7:0] fw);
        return {base[31], run, trig, fw, base[5:0]};
    endfunction

    task automatic bus_cycle(input logic we, input logic [11:0] addr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int t;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, sel: 4'hf, dat: wdat};
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!wb_rsp.ack && t < TIMEOUT);
        assert (wb_rsp.ack) else begin
            timeout_errors++;
            $display("timeout: no ack from the bus at address %h", addr);
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        #10;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [11:0] addr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, wdat, unused);
    endtask

    task automatic wb_read(input logic [11:0] addr, output logic [31:0] rdat);
        bus_cycle(1'b0, addr, 32'd0, rdat);
    endtask

    task automatic send_turf(input logic [31:0] w);
        turf_word   = w;
        turf_strobe = 1'b1;
        @(posedge clk);
        #10;
        turf_strobe = 1'b0;
    endtask

    // returns on the falling edge where sync is seen high
    task automatic wait_sync();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (sync !== 1'b1 && t < TIMEOUT);
        assert (sync === 1'b1) else begin
            timeout_errors++;
            $display("timeout: no sync pulse seen");
        end
    endtask

    task automatic align_to_window();
        wait_sync();
        repeat (3) @(posedge clk);
        #10;
    endtask

    // bit 31 shows up two cycles after sync, one bit per cycle after that
    task automatic capture_word(input int line, output logic [31:0] w);
        wait_sync();
        repeat (2) @(negedge clk);
        for (int i = 31; i >= 0; i--) begin
            w[i] = cin[line];
            if (i > 0) @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic reset_values();
        check_value("wb_rsp_o.ack", 32'(wb_rsp.ack), 32'd0);
        check_value("command_valid_o", 32'(command_valid), 32'd0);
        check_value("command_locked_o", 32'(command_locked), 32'd0);
        check_value("mode1_tready_o", 32'(mode1_tready), 32'd1);
        check_value("cin_o", 32'(cin), 32'd0);
        wb_read(core_adr(3), rdata);
        check_value("core pending bits", rdata, 32'd0);
    endtask

    task automatic lock_sequence();
        repeat (3) send_turf(`SURFTURF_TRAIN_SEQ);
        check_value("command_locked_o", 32'(command_locked), 32'd0);
        send_turf(`SURFTURF_TRAIN_SEQ);
        check_value("command_locked_o", 32'(command_locked), 32'd1);
        send_turf(TURF_CMD);
        check_value("command_valid_o", 32'(command_valid), 32'd1);
        check_value("command_o", command, TURF_CMD);
        @(posedge clk);
        #10;
        check_value("command_valid_o", 32'(command_valid), 32'd0);
        wb_read(slot_adr(0, 1), rdata);
        check_value("turf command count", rdata, 32'd1);
        response = RESP_VAL;
        wb_read(slot_adr(0, 3), rdata);
        check_value("turf response", rdata, RESP_VAL);
    endtask

    task automatic training_pattern();
        capture_word(SURF_SEL, word);
        check_value($sformatf("cin_o[%0d] word", SURF_SEL), word, `SURFTURF_TRAIN_SEQ);
    endtask

    task automatic pass_through();
        wb_write(slot_adr(SURF_SEL + 1, 0), 32'd1);
        capture_word(SURF_SEL, word);
        check_value($sformatf("cin_o[%0d] word", SURF_SEL), word, TURF_CMD);
        wb_read(slot_adr(SURF_SEL + 1, 1), rdata);
        check_value("surf sent count", rdata, 32'd1);
    endtask

    task automatic register_splice();
        logic [14:0] trig_val;
        trig_val = 15'($random(seed));
        align_to_window();
        wb_write(core_adr(0), 32'(RUNCMD_START));
        wb_write(core_adr(1), {17'd0, trig_val});
        wb_write(core_adr(2), 32'h0000_00c3);
        capture_word(SURF_SEL, word);
        check_value("spliced word", word, splice_word(TURF_CMD, RUNCMD_START, trig_val, 8'hc3));
        // nothing pending any more, the TURF command goes out unchanged
        capture_word(SURF_SEL, word);
        check_value("word after splice", word, TURF_CMD);
    endtask

    task automatic mode1_priority_and_pps();
        logic [31:0] exp_word;
        align_to_window();
        check_value("mode1_tready_o", 32'(mode1_tready), 32'd1);
        mode1 = '{valid: 1'b1, data: 15'h00a6, target: TGT_FW};
        @(posedge clk);
        #10;
        mode1.valid = 1'b0;
        check_value("mode1_tready_o", 32'(mode1_tready), 32'd0);
        // core fw beat has to stall behind the mode1 byte
        wb_write(core_adr(2), 32'h0000_003c);
        wb_read(core_adr(3), rdata);
        check_value("core pending bits", rdata, 32'h4);
        capture_word(SURF_SEL, word);
        check_value("mode1 fw word", word,
                    splice_word(TURF_CMD, TURF_CMD[30:29], TURF_CMD[28:14], 8'ha6));
        use_tfio_pps = 1'b1;
        tfio_pps     = 1'b1;
        @(posedge clk);
        #10;
        tfio_pps = 1'b0;
        capture_word(SURF_SEL, word);
        exp_word     = splice_word(TURF_CMD, TURF_CMD[30:29], TURF_CMD[28:14], 8'h3c);
        exp_word[31] = 1'b1;
        check_value("core fw and pps word", word, exp_word);
        use_tfio_pps = 1'b0;
    endtask

    task automatic relock_and_decode();
        wb_read(slot_adr(0, 0), rdata);
        check_value("lock state", rdata, 32'(LOCK_LOCKED));
        wb_write(slot_adr(0, 0), 32'd1);
        check_value("command_locked_o", 32'(command_locked), 32'd0);
        wb_read(slot_adr(0, 0), rdata);
        check_value("lock state", rdata, 32'(LOCK_HUNT));
        align_to_window();
        for (int s = 0; s < `SURFTURF_NUM_SURF; s++) begin
            wb_read(slot_adr(s + 1, 2), rdata);
            check_value($sformatf("surf %0d last word", s), rdata,
                        (s == SURF_SEL) ? TURF_CMD : `SURFTURF_TRAIN_SEQ);
        end
    endtask

    initial begin
        seed           = 32'hb44808d8;
        value_errors   = 0;
        timeout_errors = 0;
        rst_n          = 1'b0;
        wb_req         = '0;
        turf_word      = '0;
        turf_strobe    = 1'b0;
        response       = 32'h0;
        mode1          = '0;
        tfio_pps       = 1'b0;
        use_tfio_pps   = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        reset_values();
        lock_sequence();
        training_pattern();
        pass_through();
        register_splice();
        mode1_priority_and_pps();
        relock_and_decode();
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/surfturf_wrapper.sv */
`timescale 1ns/1ns
`include "surfturf_consts.svh"
`default_nettype none

module surfturf_wrapper (
    input  wire                          sysclk_i,
    input  wire                          rst_n_i,
    input  wire rackbus_pkg::wb_req_t    wb_req_i,
    input  wire                          sync_i,
    input  wire [31:0]                   turf_word_i,
    input  wire                          turf_word_strobe_i,
    input  wire [31:0]                   response_i,
    input  wire turfio_pkg::tfio_beat_t  mode1_i,
    input  wire                          tfio_pps_i,
    input  wire                          use_tfio_pps_i,
    output rackbus_pkg::wb_rsp_t         wb_rsp_o,
    output logic                         mode1_tready_o,
    output turfio_pkg::surf_cmd_t        command_o,
    output logic                         command_valid_o,
    output logic                         command_locked_o,
    output logic [`SURFTURF_NUM_SURF-1:0] cin_o
);
    import rackbus_pkg::*;
    import turfio_pkg::*;

    // slot 0 is the TURF link, the SURF ports follow
    localparam int NSLOT = `SURFTURF_NUM_SURF + 1;

    logic                        core_sel;
    logic [`SURFTURF_SLOT_W-1:0] slot;
    wb_req_t                     core_req;
    wb_rsp_t                     core_rsp;
    wb_req_t                     slot_req [NSLOT];
    wb_rsp_t                     slot_rsp [NSLOT];
    tfio_beat_t                  runcmd_b;
    tfio_beat_t                  trig_b;
    tfio_beat_t                  fw_b;
    logic                        runcmd_rdy;
    logic                        trig_rdy;
    logic                        fw_rdy;
    surf_cmd_t                   spliced;
    logic                        spliced_valid;

    assign core_sel = wb_req_i.adr[`SURFTURF_CORE_BIT];
    assign slot     = wb_req_i.adr[`SURFTURF_SLOT_LSB +: `SURFTURF_SLOT_W];

    // every slave sees the request, only the addressed one gets stb
    always_comb begin
        core_req     = wb_req_i;
        core_req.stb = wb_req_i.stb && core_sel;
        for (int i = 0; i < NSLOT; i++) begin
            slot_req[i]     = wb_req_i;
            slot_req[i].stb = wb_req_i.stb && !core_sel && slot == `SURFTURF_SLOT_W'(i);
        end
    end

    assign wb_rsp_o = core_sel ? core_rsp : slot_rsp[slot];

    surfturf_register_core u_core (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i),
        .wb_req_i(core_req), .wb_rsp_o(core_rsp),
        .runcmd_ready_i(runcmd_rdy), .trig_ready_i(trig_rdy), .fw_ready_i(fw_rdy),
        .runcmd_o(runcmd_b), .trig_o(trig_b), .fw_o(fw_b));

    turfio_cmd_splice u_splice (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .sync_i(sync_i),
        .command_i(command_o), .command_valid_i(command_valid_o),
        .mode1_i(mode1_i), .runcmd_i(runcmd_b), .trig_i(trig_b), .fw_i(fw_b),
        .tfio_pps_i(tfio_pps_i), .use_tfio_pps_i(use_tfio_pps_i),
        .mode1_tready_o(mode1_tready_o), .runcmd_ready_o(runcmd_rdy),
        .trig_ready_o(trig_rdy), .fw_ready_o(fw_rdy),
        .spliced_o(spliced), .spliced_valid_o(spliced_valid));

    turf_command_link u_turf (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i),
        .wb_req_i(slot_req[0]), .wb_rsp_o(slot_rsp[0]),
        .turf_word_i(turf_word_i), .turf_word_strobe_i(turf_word_strobe_i),
        .response_i(response_i), .command_o(command_o),
        .command_valid_o(command_valid_o), .command_locked_o(command_locked_o));

    for (genvar g = 0; g < `SURFTURF_NUM_SURF; g++) begin : g_surf
        surf_command_port u_surf (
            .sysclk_i(sysclk_i), .rst_n_i(rst_n_i),
            .wb_req_i(slot_req[g+1]), .wb_rsp_o(slot_rsp[g+1]),
            .cmd_i(spliced), .cmd_valid_i(spliced_valid), .cin_o(cin_o[g]));
    end

endmodule

`default_nettype wire

/* hdl/surf_command_port.sv */
`timescale 1ns/1ns
`include "surfturf_consts.svh"
`default_nettype none

module surf_command_port (
    input  wire                        sysclk_i,
    input  wire                        rst_n_i,
    input  wire rackbus_pkg::wb_req_t  wb_req_i,
    input  wire turfio_pkg::surf_cmd_t cmd_i,
    input  wire                        cmd_valid_i,
    output rackbus_pkg::wb_rsp_t       wb_rsp_o,
    output logic                       cin_o
);
    logic        enable_q;
    logic [31:0] shift_q;
    logic [31:0] sent_cnt_q;
    logic [31:0] last_q;
    logic [31:0] load_word;
    logic        ack_q;
    logic [31:0] rdat_q;
    logic        reg_hit;
    logic [1:0]  reg_idx;

    assign reg_hit   = wb_req_i.adr[`SURFTURF_SLOT_LSB-1:4] == '0;
    assign reg_idx   = wb_req_i.adr[3:2];
    // disabled ports keep sending training so the SURF stays aligned
    assign load_word = enable_q ? cmd_i : `SURFTURF_TRAIN_SEQ;
    assign cin_o     = shift_q[31];

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q   <= 1'b0;
            shift_q    <= '0;
            sent_cnt_q <= '0;
            ack_q      <= 1'b0;
        end else begin
            ack_q <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
            if (wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && !ack_q
                && reg_hit && reg_idx == 2'd0) begin
                enable_q <= wb_req_i.dat[0];
            end
            if (cmd_valid_i) begin
                shift_q <= load_word;
                if (enable_q) sent_cnt_q <= sent_cnt_q + 1'b1;
            end else begin
                // msb first, last bit is repeated until the next load
                shift_q <= {shift_q[30:0], shift_q[0]};
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (cmd_valid_i) last_q <= load_word;
        if (!reg_hit) rdat_q <= '0;
        else begin
            case (reg_idx)
                2'd0:    rdat_q <= {31'd0, enable_q};
                2'd1:    rdat_q <= sent_cnt_q;
                2'd2:    rdat_q <= last_q;
                default: rdat_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

/* hdl/turf_command_link.sv */
`timescale 1ns/1ns
`include "surfturf_consts.svh"
`default_nettype none

module turf_command_link (
    input  wire                        sysclk_i,
    input  wire                        rst_n_i,
    input  wire rackbus_pkg::wb_req_t  wb_req_i,
    input  wire [31:0]                 turf_word_i,
    input  wire                        turf_word_strobe_i,
    input  wire [31:0]                 response_i,
    output rackbus_pkg::wb_rsp_t       wb_rsp_o,
    output turfio_pkg::surf_cmd_t      command_o,
    output logic                       command_valid_o,
    output logic                       command_locked_o
);
    import turfio_pkg::*;

    localparam int CNT_W = $clog2(`SURFTURF_LOCK_COUNT);

    lock_state_e      state_q;
    logic [CNT_W-1:0] train_cnt_q;
    logic [31:0]      cmd_count_q;
    logic             ack_q;
    logic [31:0]      rdat_q;
    logic             bus_req;
    logic             reg_hit;
    logic [1:0]       reg_idx;
    logic             relock;
    logic             is_train;

    assign bus_req  = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign reg_hit  = wb_req_i.adr[`SURFTURF_SLOT_LSB-1:4] == '0;
    assign reg_idx  = wb_req_i.adr[3:2];
    assign relock   = bus_req && wb_req_i.we && reg_hit && reg_idx == 2'd0 && wb_req_i.dat[0];
    assign is_train = turf_word_i == `SURFTURF_TRAIN_SEQ;

    assign command_locked_o = state_q == LOCK_LOCKED;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q         <= LOCK_HUNT;
            train_cnt_q     <= '0;
            cmd_count_q     <= '0;
            command_valid_o <= 1'b0;
            ack_q           <= 1'b0;
        end else begin
            ack_q           <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
            command_valid_o <= 1'b0;
            if (relock) begin
                state_q     <= LOCK_HUNT;
                train_cnt_q <= '0;
            end else if (turf_word_strobe_i) begin
                case (state_q)
                    LOCK_HUNT, LOCK_TRAIN: begin
                        if (!is_train) begin
                            state_q     <= LOCK_HUNT;
                            train_cnt_q <= '0;
                        end else if (train_cnt_q == CNT_W'(`SURFTURF_LOCK_COUNT - 1)) begin
                            state_q     <= LOCK_LOCKED;
                            train_cnt_q <= '0;
                        end else begin
                            state_q     <= LOCK_TRAIN;
                            train_cnt_q <= train_cnt_q + 1'b1;
                        end
                    end
                    LOCK_LOCKED: begin
                        // training words between commands are just idle fill
                        if (!is_train) begin
                            command_valid_o <= 1'b1;
                            cmd_count_q     <= cmd_count_q + 1'b1;
                        end
                    end
                    default: state_q <= LOCK_HUNT;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (turf_word_strobe_i && command_locked_o && !is_train) command_o <= turf_word_i;
        if (!reg_hit) rdat_q <= '0;
        else begin
            case (reg_idx)
                2'd0:    rdat_q <= {30'd0, state_q};
                2'd1:    rdat_q <= cmd_count_q;
                2'd2:    rdat_q <= command_o;
                default: rdat_q <= response_i;
            endcase
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

    a_cmd_needs_lock: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        command_valid_o |-> $past(command_locked_o));

endmodule

`default_nettype wire

/* hdl/turfio_cmd_splice.sv */
`timescale 1ns/1ns
`default_nettype none

module turfio_cmd_splice (
    input  wire                          sysclk_i,
    input  wire                          rst_n_i,
    input  wire                          sync_i,
    input  wire turfio_pkg::surf_cmd_t   command_i,
    input  wire                          command_valid_i,
    input  wire turfio_pkg::tfio_beat_t  mode1_i,
    input  wire turfio_pkg::tfio_beat_t  runcmd_i,
    input  wire turfio_pkg::tfio_beat_t  trig_i,
    input  wire turfio_pkg::tfio_beat_t  fw_i,
    input  wire                          tfio_pps_i,
    input  wire                          use_tfio_pps_i,
    output logic                         mode1_tready_o,
    output logic                         runcmd_ready_o,
    output logic                         trig_ready_o,
    output logic                         fw_ready_o,
    output turfio_pkg::surf_cmd_t        spliced_o,
    output logic                         spliced_valid_o
);
    import turfio_pkg::*;

    surf_cmd_t   cmd_q;
    surf_cmd_t   nxt;
    runcmd_e     run_q;
    logic [14:0] trig_q;
    logic [7:0]  fw_q;
    logic        pps_q;
    // one pending flag per target, trig is split into low and high parts
    logic [3:0]  pend_q;
    logic [3:0]  m1_take;
    logic [3:0]  core_take;
    logic [3:0]  take;

    assign mode1_tready_o = !pend_q[mode1_i.target];

    always_comb begin
        m1_take = '0;
        if (mode1_i.valid && mode1_tready_o) m1_take[mode1_i.target] = 1'b1;
    end

    // mode1 gets the field first when both offer it in one cycle
    assign runcmd_ready_o = !pend_q[TGT_RUNCMD] && !m1_take[TGT_RUNCMD];
    assign fw_ready_o     = !pend_q[TGT_FW] && !m1_take[TGT_FW];
    assign trig_ready_o   = !(pend_q[TGT_TRIG_LO] || pend_q[TGT_TRIG_HI]
                              || m1_take[TGT_TRIG_LO] || m1_take[TGT_TRIG_HI]);

    always_comb begin
        core_take = '0;
        core_take[TGT_RUNCMD]  = runcmd_i.valid && runcmd_ready_o;
        core_take[TGT_FW]      = fw_i.valid && fw_ready_o;
        core_take[TGT_TRIG_LO] = trig_i.valid && trig_ready_o;
        core_take[TGT_TRIG_HI] = trig_i.valid && trig_ready_o;
    end

    assign take = m1_take | core_take;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_q           <= '0;
            pend_q          <= '0;
            pps_q           <= 1'b0;
            spliced_valid_o <= 1'b0;
        end else begin
            if (command_valid_i) cmd_q <= command_i;
            // a beat taken during sync lands in the next window
            pend_q          <= (sync_i ? 4'd0 : pend_q) | take;
            pps_q           <= !sync_i && (pps_q || tfio_pps_i);
            spliced_valid_o <= sync_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (m1_take[TGT_RUNCMD]) run_q <= runcmd_e'(mode1_i.data[1:0]);
        else if (core_take[TGT_RUNCMD]) run_q <= runcmd_e'(runcmd_i.data[1:0]);
        if (m1_take[TGT_FW]) fw_q <= mode1_i.data[7:0];
        else if (core_take[TGT_FW]) fw_q <= fw_i.data[7:0];
        if (m1_take[TGT_TRIG_LO]) trig_q[7:0] <= mode1_i.data[7:0];
        if (m1_take[TGT_TRIG_HI]) trig_q[14:8] <= mode1_i.data[6:0];
        if (core_take[TGT_TRIG_LO]) trig_q <= trig_i.data;
        if (sync_i) spliced_o <= nxt;
    end

    always_comb begin
        nxt = cmd_q;
        if (pend_q[TGT_RUNCMD]) nxt.runcmd = run_q;
        if (pend_q[TGT_TRIG_LO]) nxt.trig[7:0] = trig_q[7:0];
        if (pend_q[TGT_TRIG_HI]) nxt.trig[14:8] = trig_q[14:8];
        if (pend_q[TGT_FW]) nxt.fw = fw_q;
        nxt.pps = use_tfio_pps_i ? (pps_q || tfio_pps_i) : cmd_q.pps;
    end

    // once a field has taken a beat it stays closed for the rest of the window
    a_one_per_field: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        (take & $past(take)) == '0);

endmodule

`default_nettype wire

/* hdl/surfturf_register_core.sv */
`timescale 1ns/1ns
`include "surfturf_consts.svh"
`default_nettype none

module surfturf_register_core (
    input  wire                        sysclk_i,
    input  wire                        rst_n_i,
    input  wire rackbus_pkg::wb_req_t  wb_req_i,
    input  wire                        runcmd_ready_i,
    input  wire                        trig_ready_i,
    input  wire                        fw_ready_i,
    output rackbus_pkg::wb_rsp_t       wb_rsp_o,
    output turfio_pkg::tfio_beat_t     runcmd_o,
    output turfio_pkg::tfio_beat_t     trig_o,
    output turfio_pkg::tfio_beat_t     fw_o
);
    import turfio_pkg::*;

    logic        ack_q;
    logic [31:0] rdat_q;
    logic [2:0]  vld_q;
    logic [14:0] dat_q [3];
    logic [2:0]  rdy;
    logic [2:0]  load;
    logic        wr_en;
    logic        reg_hit;
    logic [1:0]  reg_idx;

    assign reg_hit = wb_req_i.adr[`SURFTURF_CORE_BIT-1:4] == '0;
    assign reg_idx = wb_req_i.adr[3:2];
    assign wr_en   = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && !ack_q && reg_hit;
    assign rdy     = {fw_ready_i, trig_ready_i, runcmd_ready_i};

    // a write to a channel still waiting on the splice is dropped
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            load[i] = wr_en && reg_idx == 2'(i) && !vld_q[i];
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            vld_q <= '0;
        end else begin
            ack_q <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
            vld_q <= (vld_q & ~rdy) | load;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (load[0]) dat_q[0] <= {13'd0, wb_req_i.dat[1:0]};
        if (load[1]) dat_q[1] <= wb_req_i.dat[14:0];
        if (load[2]) dat_q[2] <= {7'd0, wb_req_i.dat[7:0]};
        if (!reg_hit) rdat_q <= '0;
        else if (reg_idx == 2'd3) rdat_q <= {29'd0, vld_q};
        else rdat_q <= {17'd0, dat_q[reg_idx]};
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};
    assign runcmd_o = '{valid: vld_q[0], data: dat_q[0], target: TGT_RUNCMD};
    assign trig_o   = '{valid: vld_q[1], data: dat_q[1], target: TGT_TRIG_LO};
    assign fw_o     = '{valid: vld_q[2], data: dat_q[2], target: TGT_FW};

    // a stalled beat keeps its data until the splice takes it
    for (genvar g = 0; g < 3; g++) begin : g_hold
        a_beat_hold: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
            vld_q[g] && !rdy[g] |=> $stable(dat_q[g]));
    end

endmodule

`default_nettype wire

/* hdl/turfio_pkg.sv */
`default_nettype none

package turfio_pkg;

    typedef enum logic [1:0] {
        RUNCMD_NOP   = 2'd0,
        RUNCMD_SYNC  = 2'd1,
        RUNCMD_START = 2'd2,
        RUNCMD_STOP  = 2'd3
    } runcmd_e;

    // command word as seen on a SURF line, msb goes out first
    typedef struct packed {
        logic        pps;
        runcmd_e     runcmd;
        logic [14:0] trig;
        logic [7:0]  fw;
        logic [5:0]  turf_low;
    } surf_cmd_t;

    // which field of the command word a beat is meant for
    typedef enum logic [1:0] {
        TGT_FW      = 2'd0,
        TGT_RUNCMD  = 2'd1,
        TGT_TRIG_LO = 2'd2,
        TGT_TRIG_HI = 2'd3
    } tfio_tgt_e;

    typedef struct packed {
        logic        valid;
        logic [14:0] data;
        tfio_tgt_e   target;
    } tfio_beat_t;

    typedef enum logic [1:0] {
        LOCK_HUNT   = 2'd0,
        LOCK_TRAIN  = 2'd1,
        LOCK_LOCKED = 2'd2
    } lock_state_e;

endpackage

`default_nettype wire

/* hdl/rackbus_pkg.sv */
`include "surfturf_consts.svh"
`default_nettype none

package rackbus_pkg;

    // classic single-beat Wishbone request, byte addressed
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`SURFTURF_ADR_W-1:0] adr;
        logic [3:0]                 sel;
        logic [31:0]                dat;
    } wb_req_t;

    // no err or rty, a slave always acks
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/surfturf_consts.svh */
`ifndef SURFTURF_CONSTS_SVH
`define SURFTURF_CONSTS_SVH
`default_nettype none

// number of SURF command lines driven from this block
`define SURFTURF_NUM_SURF 7

// training word sent by the TURF, also sent on disabled SURF lines
`define SURFTURF_TRAIN_SEQ 32'hA55A6996

// consecutive training words needed before the TURF link is locked
`define SURFTURF_LOCK_COUNT 4

// register bus address map
`define SURFTURF_ADR_W 12
`define SURFTURF_SLOT_LSB 6
`define SURFTURF_SLOT_W 3

// upper half of the space goes to the splice register core
`define SURFTURF_CORE_BIT 11

`default_nettype wire
`endif
